//--- logic/conv_data_pkg.sv
// operands are signed 16 bit; 4 guard bits hold at most 16 full-scale products without overflow.
package conv_data_pkg;

    // signed operand width.
    localparam int WORD_W = 16;

    // two operand widths plus 4 guard bits.
    localparam int ACC_W = 2 * WORD_W + 4;

    // one bank entry.
    typedef logic signed [WORD_W-1:0] conv_word_t;

    // finished dot product as returned to the host.
    typedef struct packed {
        logic signed [ACC_W-1:0] sum;
    } conv_result_t;

endpackage

//--- logic/conv_cmd_pkg.sv
// opcodes 5 to 7 are not commands; they complete like a clear and change no state.
package conv_cmd_pkg;

    import conv_data_pkg::*;

    typedef enum logic [2:0] {
        OP_LOAD_W  = 3'd0,
        OP_CLEAR_W = 3'd1,
        OP_LOAD_X  = 3'd2,
        OP_CLEAR_X = 3'd3,
        OP_RUN     = 3'd4
    } conv_op_e;

    // one host command, 36 bits.
    typedef struct packed {
        conv_op_e   op;
        // write word1 as well.
        logic       two_words;
        conv_word_t word0;
        conv_word_t word1;
    } conv_cmd_t;

endpackage

//--- logic/conv_cmd_port.sv
// one command outstanding at a time; cmd_i must stay stable while cmd_req_i is high.
`timescale 1ns/1ps

module conv_cmd_port (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    cmd_req_i,
    input  conv_cmd_pkg::conv_cmd_t cmd_i,
    output logic                    cmd_ack_o,
    output logic                    issue_o,
    output conv_cmd_pkg::conv_cmd_t cmd_o,
    input  logic                    finish_i
);

    import conv_cmd_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_BUSY,
        P_ACKED
    } port_state_e;

    port_state_e state;
    logic        issue_q;
    conv_cmd_t   cmd_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= P_IDLE;
            issue_q <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (cmd_req_i) begin
                        issue_q <= 1'b1;
                        state   <= P_BUSY;
                    end
                end
                P_BUSY: begin
                    if (finish_i) begin
                        state <= P_ACKED;
                    end
                end
                P_ACKED: begin
                    // wait for the host to drop req.
                    if (!cmd_req_i) begin
                        state <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // command is held until the next acceptance.
    always_ff @(posedge clk_i) begin
        if (state == P_IDLE && cmd_req_i) begin
            cmd_q <= cmd_i;
        end
    end

    assign issue_o   = issue_q;
    assign cmd_o     = cmd_q;
    assign cmd_ack_o = (state == P_ACKED);

endmodule

//--- logic/conv_sequencer.sv
// DEPTH must be a power of two from 2 to 16; a RUN waits while the result port is busy.
`timescale 1ns/1ps

module conv_sequencer #(
    parameter int DEPTH = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    issue_i,
    input  conv_cmd_pkg::conv_cmd_t cmd_i,
    output logic                    finish_o,
    input  logic                    busy_i,
    output logic                    x_wr_o,
    output logic                    x_wr2_o,
    output logic                    x_clr_o,
    output logic                    w_wr_o,
    output logic                    w_wr2_o,
    output logic                    w_clr_o,
    output logic                    run_start_o,
    output logic                    rd_adv_o,
    output logic                    mac_start_o,
    output logic                    mac_valid_o,
    output logic                    mac_last_o
);

    import conv_cmd_pkg::*;

    localparam int CW = $clog2(DEPTH);
    localparam logic [CW-1:0] LAST = CW'(DEPTH - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_READ,
        S_FLUSH
    } seq_state_e;

    seq_state_e    state;
    logic [CW-1:0] cnt;
    logic          finish_q;

    // bank strobes last only for the issue cycle.
    always_comb begin
        x_wr_o  = 1'b0;
        x_wr2_o = 1'b0;
        x_clr_o = 1'b0;
        w_wr_o  = 1'b0;
        w_wr2_o = 1'b0;
        w_clr_o = 1'b0;
        if (issue_i) begin
            case (cmd_i.op)
                OP_LOAD_W: begin
                    w_wr_o  = 1'b1;
                    w_wr2_o = cmd_i.two_words;
                end
                OP_CLEAR_W: w_clr_o = 1'b1;
                OP_LOAD_X: begin
                    x_wr_o  = 1'b1;
                    x_wr2_o = cmd_i.two_words;
                end
                OP_CLEAR_X: x_clr_o = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= S_IDLE;
            cnt      <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (issue_i) begin
                        if (cmd_i.op == OP_RUN) begin
                            state <= S_WAIT;
                        end else begin
                            finish_q <= 1'b1;
                        end
                    end
                end
                S_WAIT: begin
                    if (!busy_i) begin
                        cnt   <= '0;
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state <= S_FLUSH;
                    end
                end
                S_FLUSH: begin
                    // lines finish up with the mac done pulse.
                    finish_q <= 1'b1;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign finish_o    = finish_q;
    assign run_start_o = (state == S_WAIT) && !busy_i;
    assign mac_start_o = run_start_o;
    assign rd_adv_o    = (state == S_READ);
    assign mac_valid_o = rd_adv_o;
    assign mac_last_o  = rd_adv_o && (cnt == LAST);

endmodule

//--- logic/conv_operand_bank.sv
// DEPTH must be a power of two; pointers wrap modulo DEPTH and unwritten entries read zero.
`timescale 1ns/1ps

module conv_operand_bank #(
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     clr_i,
    input  logic                     wr_i,
    input  logic                     wr2_i,
    input  conv_data_pkg::conv_word_t word0_i,
    input  conv_data_pkg::conv_word_t word1_i,
    input  logic                     run_start_i,
    input  logic                     rd_adv_i,
    output conv_data_pkg::conv_word_t rd_word_o
);

    import conv_data_pkg::*;

    localparam int AW = $clog2(DEPTH);

    conv_word_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            wr_ptr <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_i) begin
            mem[wr_ptr] <= word0_i;
            if (wr2_i) begin
                mem[wr_ptr + AW'(1)] <= word1_i;
            end
            wr_ptr <= wr_ptr + (wr2_i ? AW'(2) : AW'(1));
        end
    end

    // read side walks from entry 0 on each run.
    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i || run_start_i) begin
            rd_ptr <= '0;
        end else if (rd_adv_i) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign rd_word_o = mem[rd_ptr];

endmodule

//--- logic/conv_mac.sv
// no saturation; the sum wraps if more than sixteen full-scale products are added.
`timescale 1ns/1ps

module conv_mac (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  logic                       valid_i,
    input  conv_data_pkg::conv_word_t   x_i,
    input  conv_data_pkg::conv_word_t   w_i,
    input  logic                       last_i,
    output logic                       done_o,
    output conv_data_pkg::conv_result_t result_o
);

    import conv_data_pkg::*;

    logic signed [2*WORD_W-1:0] prod_q;
    logic                       valid_q;
    logic                       last_q;
    logic signed [ACC_W-1:0]    acc_q;
    logic                       done_q;

    // product stage.
    always_ff @(posedge clk_i) begin
        prod_q <= x_i * w_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            last_q  <= valid_i && last_i;
            done_q  <= valid_q && last_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q <= '0;
        end else if (valid_q) begin
            acc_q <= acc_q + ACC_W'(prod_q);
        end
    end

    assign done_o       = done_q;
    assign result_o.sum = acc_q;

endmodule

//--- logic/conv_result_port.sv
// one result is held at a time; busy stays high until the host drops res_ack_i.
`timescale 1ns/1ps

module conv_result_port (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       done_i,
    input  conv_data_pkg::conv_result_t result_i,
    output logic                       busy_o,
    output logic                       res_req_o,
    input  logic                       res_ack_i,
    output conv_data_pkg::conv_result_t res_o
);

    import conv_data_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_DROP
    } res_state_e;

    res_state_e   state;
    conv_result_t res_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE: if (done_i) state <= R_REQ;
                R_REQ:  if (res_ack_i) state <= R_DROP;
                // host still holds ack.
                R_DROP: if (!res_ack_i) state <= R_IDLE;
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == R_IDLE && done_i) begin
            res_q <= result_i;
        end
    end

    assign busy_o    = done_i || (state != R_IDLE);
    assign res_req_o = (state == R_REQ);
    assign res_o     = res_q;

endmodule

//--- logic/conv_accel_top.sv
// DEPTH must be a power of two from 2 to 16; host and accelerator share clk_i.
`timescale 1ns/1ps

module conv_accel_top #(
    parameter int DEPTH = 16
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       cmd_req_i,
    input  conv_cmd_pkg::conv_cmd_t     cmd_i,
    output logic                       cmd_ack_o,
    output logic                       res_req_o,
    input  logic                       res_ack_i,
    output conv_data_pkg::conv_result_t res_o
);

    import conv_cmd_pkg::*;
    import conv_data_pkg::*;

    logic         issue;
    logic         finish;
    conv_cmd_t    cmd;
    logic         busy;
    logic         x_wr, x_wr2, x_clr;
    logic         w_wr, w_wr2, w_clr;
    logic         run_start, rd_adv;
    logic         mac_start, mac_valid, mac_last;
    conv_word_t   x_word, w_word;
    logic         done;
    conv_result_t result;

    conv_cmd_port cmd_port0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .cmd_req_i(cmd_req_i), .cmd_i(cmd_i), .cmd_ack_o(cmd_ack_o),
        .issue_o(issue), .cmd_o(cmd), .finish_i(finish)
    );

    conv_sequencer #(.DEPTH(DEPTH)) seq0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .issue_i(issue), .cmd_i(cmd), .finish_o(finish), .busy_i(busy),
        .x_wr_o(x_wr), .x_wr2_o(x_wr2), .x_clr_o(x_clr),
        .w_wr_o(w_wr), .w_wr2_o(w_wr2), .w_clr_o(w_clr),
        .run_start_o(run_start), .rd_adv_o(rd_adv),
        .mac_start_o(mac_start), .mac_valid_o(mac_valid), .mac_last_o(mac_last)
    );

    conv_operand_bank #(.DEPTH(DEPTH)) x_bank (
        .clk_i(clk_i), .rst_i(rst_i), .clr_i(x_clr), .wr_i(x_wr), .wr2_i(x_wr2),
        .word0_i(cmd.word0), .word1_i(cmd.word1),
        .run_start_i(run_start), .rd_adv_i(rd_adv), .rd_word_o(x_word)
    );

    conv_operand_bank #(.DEPTH(DEPTH)) w_bank (
        .clk_i(clk_i), .rst_i(rst_i), .clr_i(w_clr), .wr_i(w_wr), .wr2_i(w_wr2),
        .word0_i(cmd.word0), .word1_i(cmd.word1),
        .run_start_i(run_start), .rd_adv_i(rd_adv), .rd_word_o(w_word)
    );

    conv_mac mac0 (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(mac_start), .valid_i(mac_valid),
        .x_i(x_word), .w_i(w_word), .last_i(mac_last),
        .done_o(done), .result_o(result)
    );

    conv_result_port res_port0 (
        .clk_i(clk_i), .rst_i(rst_i), .done_i(done), .result_i(result),
        .busy_o(busy), .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_o(res_o)
    );

endmodule

//--- tests/conv_accel_tb.sv
// runs with DEPTH 16 only; the model expects results back in RUN order and a shared clock.
`timescale 1ns/1ps

module conv_accel_tb;

    import conv_cmd_pkg::*;
    import conv_data_pkg::*;

    localparam int DEPTH   = 16;
    localparam int TIMEOUT = 200;

    typedef enum logic [1:0] {
        C_IDLE,
        C_DELAY,
        C_HOLD
    } cons_state_e;

    logic         clk_i = 1'b0;
    logic         rst_i;
    logic         cmd_req_i;
    conv_cmd_t    cmd_i;
    logic         cmd_ack_o;
    logic         res_req_o;
    logic         res_ack_i;
    conv_result_t res_o;

    // reference banks, index 0 is data and 1 is weights.
    logic signed [WORD_W-1:0] mem [2][DEPTH];
    int          ptr [2];
    longint      exp_q [$];
    int          delay_q [$];
    logic [15:0] lfsr;
    string       test_name;
    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;
    cons_state_e cons_state;
    int          cons_wait;
    int          cons_hold;

    conv_accel_top #(.DEPTH(DEPTH)) dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .cmd_req_i(cmd_req_i), .cmd_i(cmd_i), .cmd_ack_o(cmd_ack_o),
        .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_o(res_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void check_value(input string what, input longint exp,
                                        input longint act);
        bit ok;
        ok = (exp == act);
        if (!ok) begin
            err_cnt++;
        end
        assert (ok) else begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endfunction

    function automatic longint model_dot();
        longint acc;
        acc = 0;
        for (int i = 0; i < DEPTH; i++) begin
            acc += longint'(mem[0][i]) * longint'(mem[1][i]);
        end
        return acc;
    endfunction

    function automatic void model_apply(input conv_cmd_t c, input int ack_delay);
        int b;
        case (c.op)
            OP_LOAD_X, OP_LOAD_W: begin
                b = (c.op == OP_LOAD_W) ? 1 : 0;
                mem[b][ptr[b]] = c.word0;
                if (c.two_words) begin
                    mem[b][(ptr[b] + 1) % DEPTH] = c.word1;
                end
                ptr[b] = (ptr[b] + (c.two_words ? 2 : 1)) % DEPTH;
            end
            OP_CLEAR_X, OP_CLEAR_W: begin
                b = (c.op == OP_CLEAR_W) ? 1 : 0;
                for (int i = 0; i < DEPTH; i++) begin
                    mem[b][i] = '0;
                end
                ptr[b] = 0;
            end
            OP_RUN: begin
                exp_q.push_back(model_dot());
                delay_q.push_back(ack_delay);
            end
            default: ;
        endcase
    endfunction

    function automatic conv_cmd_t make_cmd(input conv_op_e op, input bit two);
        conv_cmd_t c;
        c.op        = op;
        c.two_words = two;
        c.word0     = conv_word_t'(rand_bits(WORD_W));
        c.word1     = conv_word_t'(rand_bits(WORD_W));
        return c;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s in test %s", TIMEOUT, what, test_name);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic start_cmd(input conv_cmd_t c, input int ack_delay);
        model_apply(c, ack_delay);
        cmd_i     = c;
        cmd_req_i = 1'b1;
    endtask

    task automatic end_cmd();
        int n;
        n = 0;
        while (!cmd_ack_o) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > TIMEOUT) begin
                report_timeout("cmd_ack_o to rise");
            end
        end
        cmd_req_i = 1'b0;
        n = 0;
        while (cmd_ack_o) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > TIMEOUT) begin
                report_timeout("cmd_ack_o to fall");
            end
        end
    endtask

    task automatic send_cmd(input conv_cmd_t c);
        int d;
        d = (c.op == OP_RUN) ? int'(rand_bits(3)) : 0;
        start_cmd(c, d);
        end_cmd();
    endtask

    // sampled on the falling edge, away from the consumer.
    task automatic drain_results();
        int n;
        n = 0;
        while (exp_q.size() != 0 || res_req_o || res_ack_i) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) begin
                report_timeout("outstanding results");
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
    endtask

    task automatic end_test();
        drain_results();
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", test_name, err_cnt - err_mark);
        end
    endtask

    // result consumer, acks after the delay queued with each RUN.
    initial begin
        res_ack_i  = 1'b0;
        cons_state = C_IDLE;
        cons_wait  = 0;
        cons_hold  = 0;
        forever begin
            @(posedge clk_i);
            #1;
            case (cons_state)
                C_IDLE: begin
                    if (res_req_o) begin
                        cons_wait = 0;
                        assert (exp_q.size() != 0) else begin
                            $display("result arrived in test %s with no RUN outstanding",
                                     test_name);
                        end
                        if (exp_q.size() != 0) begin
                            check_value("sum", exp_q.pop_front(), longint'($signed(res_o.sum)));
                            cons_wait = delay_q.pop_front();
                        end else begin
                            err_cnt++;
                        end
                        cons_hold  = 0;
                        cons_state = C_DELAY;
                        if (cons_wait == 0) begin
                            res_ack_i  = 1'b1;
                            cons_state = C_HOLD;
                        end
                    end
                end
                C_DELAY: begin
                    cons_wait--;
                    if (cons_wait <= 0) begin
                        res_ack_i  = 1'b1;
                        cons_state = C_HOLD;
                    end
                end
                default: begin
                    if (!res_req_o) begin
                        res_ack_i  = 1'b0;
                        cons_state = C_IDLE;
                    end else begin
                        cons_hold++;
                        if (cons_hold > TIMEOUT) begin
                            report_timeout("res_req_o to fall");
                        end
                    end
                end
            endcase
        end
    end

    initial begin
        int n;
        lfsr      = 16'd61;
        cmd_req_i = 1'b0;
        cmd_i     = '0;
        rst_i     = 1'b1;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[0][i] = '0;
            mem[1][i] = '0;
        end
        ptr[0] = 0;
        ptr[1] = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        start_test("reset_state");
        check_value("cmd_ack_o", 0, longint'(cmd_ack_o));
        check_value("res_req_o", 0, longint'(res_req_o));
        send_cmd(make_cmd(OP_RUN, 1'b0));
        end_test();

        start_test("single_word_loads");
        for (int i = 0; i < DEPTH; i++) begin
            send_cmd(make_cmd(OP_LOAD_X, 1'b0));
            send_cmd(make_cmd(OP_LOAD_W, 1'b0));
        end
        send_cmd(make_cmd(OP_RUN, 1'b0));
        end_test();

        start_test("two_word_loads");
        for (int i = 0; i < DEPTH / 2; i++) begin
            send_cmd(make_cmd(OP_LOAD_X, 1'b1));
            send_cmd(make_cmd(OP_LOAD_W, 1'b1));
        end
        send_cmd(make_cmd(OP_RUN, 1'b0));
        end_test();

        // clears leave the other bank alone and refill from entry 0.
        start_test("clear_banks");
        // move both write pointers off entry 0 first.
        send_cmd(make_cmd(OP_LOAD_W, 1'b0));
        send_cmd(make_cmd(OP_LOAD_X, 1'b1));
        send_cmd(make_cmd(OP_CLEAR_W, 1'b0));
        send_cmd(make_cmd(OP_RUN, 1'b0));
        send_cmd(make_cmd(OP_LOAD_W, 1'b1));
        send_cmd(make_cmd(OP_RUN, 1'b0));
        send_cmd(make_cmd(OP_CLEAR_X, 1'b0));
        send_cmd(make_cmd(OP_RUN, 1'b0));
        send_cmd(make_cmd(OP_LOAD_X, 1'b0));
        send_cmd(make_cmd(OP_RUN, 1'b0));
        end_test();

        // a pair straddles the end of the data bank.
        start_test("pointer_wrap");
        send_cmd(make_cmd(OP_CLEAR_X, 1'b0));
        send_cmd(make_cmd(OP_CLEAR_W, 1'b0));
        for (int i = 0; i < 7; i++) begin
            send_cmd(make_cmd(OP_LOAD_X, 1'b0));
        end
        for (int i = 0; i < 6; i++) begin
            send_cmd(make_cmd(OP_LOAD_X, 1'b1));
        end
        for (int i = 0; i < 11; i++) begin
            send_cmd(make_cmd(OP_LOAD_W, 1'b1));
        end
        send_cmd(make_cmd(OP_RUN, 1'b0));
        end_test();

        start_test("back_pressure");
        send_cmd(make_cmd(OP_LOAD_X, 1'b1));
        start_cmd(make_cmd(OP_RUN, 1'b0), 30);
        end_cmd();
        check_value("res_req_o pending", 1, longint'(res_req_o));
        // loads go through while a result is held.
        send_cmd(make_cmd(OP_LOAD_W, 1'b1));
        start_cmd(make_cmd(OP_RUN, 1'b0), 2);
        n = 0;
        while (res_req_o) begin
            check_value("cmd_ack_o while result held", 0, longint'(cmd_ack_o));
            @(posedge clk_i);
            #1;
            n++;
            if (n > TIMEOUT) begin
                report_timeout("held result to be taken");
            end
        end
        check_value("hold window over 20 cycles", 1, longint'(n > 20));
        end_cmd();
        end_test();

        start_test("random_commands");
        for (int i = 0; i < 500; i++) begin
            send_cmd(make_cmd(conv_op_e'(3'(rand_bits(3))), rand_bits(1) != 0));
        end
        end_test();

        $display("summary: %0d passed, %0d failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
logic/conv_data_pkg.sv
logic/conv_cmd_pkg.sv
logic/conv_cmd_port.sv
logic/conv_sequencer.sv
logic/conv_operand_bank.sv
logic/conv_mac.sv
logic/conv_result_port.sv
logic/conv_accel_top.sv
tests/conv_accel_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := conv_accel_tb
FILELIST := files.f
OBJDIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
